/* Bender.yml */
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_data_ram.sv
  - rtl/icache_tag_store.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_top.sv
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_icache.sv

/* filelist.f */
rtl/icache_pkg.sv
rtl/icache_data_ram.sv
rtl/icache_tag_store.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
sim/tb_mem_model.sv
sim/tb_icache.sv

/* rtl/icache_ctrl.sv */
//////////////////////////////
// cache controller: request FSM, two-beat miss burst
// and the response path back to the fetch unit
//////////////////////////////
`default_nettype none

module icache_ctrl #(
  parameter  int INDEX_W = 6,
  localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  // fetch request
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  icache_pkg::addr_t   req_addr_i,
  // fetch response
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output icache_pkg::word_t   rsp_data_o,
  output icache_pkg::resp_t   rsp_resp_o,
  // memory read address
  output logic                mem_ar_valid_o,
  input  logic                mem_ar_ready_i,
  output icache_pkg::addr_t   mem_ar_addr_o,
  // memory read data
  input  logic                mem_r_valid_i,
  output logic                mem_r_ready_o,
  input  icache_pkg::word_t   mem_r_data_i,
  input  icache_pkg::resp_t   mem_r_resp_i,
  // tag store
  output logic                flush_o,
  output logic [INDEX_W-1:0]  lookup_index_o,
  output logic [TAG_W-1:0]    lookup_tag_o,
  input  logic                hit_i,
  input  logic                hit_way_i,
  input  logic                victim_way_i,
  output logic                fill_en_o,
  output logic                fill_way_o,
  output logic [INDEX_W-1:0]  fill_index_o,
  output logic [TAG_W-1:0]    fill_tag_o,
  output logic                fill_valid_o,
  output logic                touch_en_o,
  output logic                touch_way_o,
  // data ram
  output logic [INDEX_W-1:0]  rd_index_o,
  output logic                wr_en_o,
  output logic                wr_way_o,
  output logic                wr_half_o,
  output logic [INDEX_W-1:0]  wr_index_o,
  output icache_pkg::word_t   wr_data_o,
  input  icache_pkg::line_t   rd_line0_i,
  input  icache_pkg::line_t   rd_line1_i
);
  import icache_pkg::*;

  localparam int IDX_LO = OFFSET_W;
  localparam int TAG_LO = OFFSET_W + INDEX_W;

  typedef enum logic [2:0] {
    IDLE,
    HIT_RSP,
    MISS_AR,
    MISS_R,
    RSP
  } state_e;

  state_e state_q, state_d;

  logic               ready_q;
  addr_t              addr_q;     // request held until the response completes
  logic               way_q;      // hit way or victim
  logic               beat_q;     // beat number within the burst
  logic               err_q;
  word_t              word_q;     // requested word of a miss

  logic               accept;
  logic               lookup_hit;
  logic               beat;
  logic               last_beat;
  logic               beat_err;
  logic               fill_ok;
  logic               idle;
  line_t              hit_line;
  logic [INDEX_W-1:0] index_q;

  assign idle       = (state_q == IDLE);
  assign accept     = req_valid_i && ready_q;
  assign lookup_hit = hit_i && !flush_i;  // a flushing cycle never hits
  assign beat       = mem_r_valid_i && (state_q == MISS_R);
  assign last_beat  = beat && beat_q;
  assign beat_err   = (mem_r_resp_i != RESP_OKAY);
  assign fill_ok    = last_beat && !err_q && !beat_err;
  assign index_q    = addr_q[TAG_LO-1:IDX_LO];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = lookup_hit ? HIT_RSP : MISS_AR;
      HIT_RSP: if (rsp_ready_i) state_d = IDLE;
      MISS_AR: if (mem_ar_ready_i) state_d = MISS_R;
      MISS_R:  if (last_beat) state_d = RSP;
      RSP:     if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      ready_q <= 1'b0;
      beat_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == IDLE);
      if (accept) begin
        beat_q <= 1'b0;
        err_q  <= 1'b0;
      end else if (beat) begin
        beat_q <= ~beat_q;
        err_q  <= err_q | beat_err;
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= req_addr_i;
      way_q  <= lookup_hit ? hit_way_i : victim_way_i;
    end
    if (beat && (beat_q == addr_q[3])) begin
      word_q <= mem_r_data_i;
    end
  end

  // lookup straight from the request
  assign lookup_index_o = req_addr_i[TAG_LO-1:IDX_LO];
  assign lookup_tag_o   = req_addr_i[31:TAG_LO];
  assign flush_o        = flush_i && idle;

  // miss invalidates the victim on accept, a clean fill revalidates it
  assign fill_en_o    = (accept && !lookup_hit) || fill_ok;
  assign fill_way_o   = idle ? victim_way_i : way_q;
  assign fill_index_o = idle ? lookup_index_o : index_q;
  assign fill_tag_o   = idle ? lookup_tag_o : addr_q[31:TAG_LO];
  assign fill_valid_o = !idle;
  assign touch_en_o   = (accept && lookup_hit) || fill_ok;
  assign touch_way_o  = idle ? hit_way_i : way_q;

  // ram read at the accepting edge, held on the latched index afterwards
  assign rd_index_o = idle ? lookup_index_o : index_q;
  assign wr_en_o    = beat;
  assign wr_way_o   = way_q;
  assign wr_half_o  = beat_q;
  assign wr_index_o = index_q;
  assign wr_data_o  = mem_r_data_i;

  assign hit_line = way_q ? rd_line1_i : rd_line0_i;

  assign req_ready_o    = ready_q;
  assign rsp_valid_o    = (state_q == HIT_RSP) || (state_q == RSP);
  assign rsp_data_o     = (state_q == HIT_RSP) ? (addr_q[3] ? hit_line[127:64] : hit_line[63:0])
                                               : word_q;
  assign rsp_resp_o     = ((state_q == RSP) && err_q) ? RESP_SLVERR : RESP_OKAY;
  assign mem_ar_valid_o = (state_q == MISS_AR);
  assign mem_ar_addr_o  = {addr_q[31:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == MISS_R);

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o))
    else $error("read address dropped before handshake");

  // data comes from the ram on a hit, so this also covers the ram read index
  a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_resp_o))
    else $error("response changed while stalled");

endmodule

`default_nettype wire

/* rtl/icache_data_ram.sv */
//////////////////////////////
// line storage for both ways, synchronous read
// a fill writes one 64-bit half of one way per cycle
//////////////////////////////
`default_nettype none

module icache_data_ram #(
  parameter int INDEX_W = 6
) (
  input  logic               clk,
  input  logic [INDEX_W-1:0] rd_index_i,
  input  logic               wr_en_i,
  input  logic               wr_way_i,
  input  logic               wr_half_i,
  input  logic [INDEX_W-1:0] wr_index_i,
  input  icache_pkg::word_t  wr_data_i,
  output icache_pkg::line_t  rd_line0_o,
  output icache_pkg::line_t  rd_line1_o
);
  import icache_pkg::*;

  localparam int SETS = 1 << INDEX_W;

  line_t mem_q [NUM_WAYS][SETS];
  line_t rd_q  [NUM_WAYS];

  // half-line write, beat 1 lands in the upper word
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      if (wr_half_i) begin
        mem_q[wr_way_i][wr_index_i][127:64] <= wr_data_i;
      end else begin
        mem_q[wr_way_i][wr_index_i][63:0] <= wr_data_i;
      end
    end
  end

  // both ways read every cycle
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_q[w] <= mem_q[w][rd_index_i];
    end
  end

  assign rd_line0_o = rd_q[0];
  assign rd_line1_o = rd_q[1];

endmodule

`default_nettype wire

/* rtl/icache_pkg.sv */
//////////////////////////////
// shared types and constants of the instruction cache
// import inside each module body that needs them
//////////////////////////////
`default_nettype none

package icache_pkg;

  // widths that carry a meaning
  typedef logic [31:0]  addr_t;   // byte address
  typedef logic [63:0]  word_t;   // fetch word, memory beat
  typedef logic [127:0] line_t;   // two words, low word first
  typedef logic [1:0]   resp_t;

  // bus response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // line geometry
  localparam int OFFSET_W = 4;  // 16 byte lines
  localparam int NUM_WAYS = 2;

endpackage

`default_nettype wire

/* rtl/icache_tag_store.sv */
//////////////////////////////
// tag, valid and lru state of the two ways
// combinational lookup, victim choice, flush clears all valid bits
//////////////////////////////
`default_nettype none

module icache_tag_store #(
  parameter  int INDEX_W = 6,
  localparam int TAG_W   = 32 - INDEX_W - icache_pkg::OFFSET_W
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush_i,
  // lookup
  input  logic [INDEX_W-1:0] lookup_index_i,
  input  logic [TAG_W-1:0]   lookup_tag_i,
  output logic               hit_o,
  output logic               hit_way_o,
  output logic               victim_way_o,
  // fill side
  input  logic               fill_en_i,
  input  logic               fill_way_i,
  input  logic [INDEX_W-1:0] fill_index_i,
  input  logic [TAG_W-1:0]   fill_tag_i,
  input  logic               fill_valid_i,
  // lru update, applied at fill_index_i
  input  logic               touch_en_i,
  input  logic               touch_way_i
);
  import icache_pkg::*;

  localparam int SETS = 1 << INDEX_W;

  typedef logic [TAG_W-1:0] tag_t;

  tag_t                  tag_q [NUM_WAYS][SETS];
  logic [SETS-1:0]       valid_q [NUM_WAYS];
  logic [SETS-1:0]       lru_q;  // way to replace next
  logic [NUM_WAYS-1:0]   hit_vec;
  logic [NUM_WAYS-1:0]   set_valid;

  // compare both ways
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      set_valid[w] = valid_q[w][lookup_index_i];
      hit_vec[w]   = set_valid[w] && (tag_q[w][lookup_index_i] == lookup_tag_i);
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec[1];

  // an empty way first, else the lru way
  always_comb begin
    if (!set_valid[0]) begin
      victim_way_o = 1'b0;
    end else if (!set_valid[1]) begin
      victim_way_o = 1'b1;
    end else begin
      victim_way_o = lru_q[lookup_index_i];
    end
  end

  // tags carry no reset, valid bits guard them
  always_ff @(posedge clk) begin
    if (fill_en_i) begin
      tag_q[fill_way_i][fill_index_i] <= fill_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else if (fill_en_i) begin
      valid_q[fill_way_i][fill_index_i] <= fill_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lru_q <= '0;
    end else if (touch_en_i) begin
      lru_q[fill_index_i] <= ~touch_way_i;  // the other way ages
    end
  end

  // a line is never filled into a second way while still valid in the first
  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(hit_vec))
    else $error("both ways hit at index %0d", lookup_index_i);

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
//////////////////////////////
// instruction cache top level, 2-way, 16 byte lines
// INDEX_W sets the number of sets
//////////////////////////////
`default_nettype none

module icache_top #(
  parameter int INDEX_W = 6
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush_i,
  // fetch side
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  icache_pkg::addr_t req_addr_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output icache_pkg::word_t rsp_data_o,
  output icache_pkg::resp_t rsp_resp_o,
  // memory side
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output icache_pkg::addr_t mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  icache_pkg::word_t mem_r_data_i,
  input  icache_pkg::resp_t mem_r_resp_i
);
  import icache_pkg::*;

  localparam int TAG_W = 32 - INDEX_W - OFFSET_W;

  // tag store link
  logic               ts_flush;
  logic [INDEX_W-1:0] lookup_index;
  logic [TAG_W-1:0]   lookup_tag;
  logic               hit;
  logic               hit_way;
  logic               victim_way;
  logic               fill_en;
  logic               fill_way;
  logic [INDEX_W-1:0] fill_index;
  logic [TAG_W-1:0]   fill_tag;
  logic               fill_valid;
  logic               touch_en;
  logic               touch_way;

  // data ram link
  logic [INDEX_W-1:0] rd_index;
  logic               wr_en;
  logic               wr_way;
  logic               wr_half;
  logic [INDEX_W-1:0] wr_index;
  word_t              wr_data;
  line_t              rd_line0;
  line_t              rd_line1;

  icache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
    .clk, .rst, .flush_i,
    .req_valid_i, .req_ready_o, .req_addr_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_data_o, .rsp_resp_o,
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_r_valid_i, .mem_r_ready_o, .mem_r_data_i, .mem_r_resp_i,
    .flush_o        (ts_flush),
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .fill_en_o      (fill_en),
    .fill_way_o     (fill_way),
    .fill_index_o   (fill_index),
    .fill_tag_o     (fill_tag),
    .fill_valid_o   (fill_valid),
    .touch_en_o     (touch_en),
    .touch_way_o    (touch_way),
    .rd_index_o     (rd_index),
    .wr_en_o        (wr_en),
    .wr_way_o       (wr_way),
    .wr_half_o      (wr_half),
    .wr_index_o     (wr_index),
    .wr_data_o      (wr_data),
    .rd_line0_i     (rd_line0),
    .rd_line1_i     (rd_line1)
  );

  icache_tag_store #(.INDEX_W(INDEX_W)) u_tags (
    .clk, .rst,
    .flush_i        (ts_flush),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .fill_en_i      (fill_en),
    .fill_way_i     (fill_way),
    .fill_index_i   (fill_index),
    .fill_tag_i     (fill_tag),
    .fill_valid_i   (fill_valid),
    .touch_en_i     (touch_en),
    .touch_way_i    (touch_way)
  );

  icache_data_ram #(.INDEX_W(INDEX_W)) u_data (
    .clk,
    .rd_index_i (rd_index),
    .wr_en_i    (wr_en),
    .wr_way_i   (wr_way),
    .wr_half_i  (wr_half),
    .wr_index_i (wr_index),
    .wr_data_i  (wr_data),
    .rd_line0_o (rd_line0),
    .rd_line1_o (rd_line1)
  );

endmodule

`default_nettype wire

/* sim/tb_icache.sv */
//////////////////////////////
// testbench of the instruction cache
// runs a table of fetches against an lru reference model
//////////////////////////////
`default_nettype none

module tb_icache;
  timeunit 1ns;
  timeprecision 100ps;
  import icache_pkg::*;

  localparam int          INDEX_W   = 6;
  localparam int          TAG_W     = 32 - INDEX_W - OFFSET_W;
  localparam int          SETS      = 1 << INDEX_W;
  localparam word_t       PATTERN   = 64'h5a5a_3c3c_a5a5_c3c3;
  localparam addr_t       ERR_BASE  = 32'h0008_0000;  // lines answered with an error
  localparam addr_t       ERR_LIMIT = 32'h0008_0100;
  localparam int unsigned SEED      = 32'h645f;

  typedef struct {
    string name;
    addr_t addr;
    bit    flush;  // pulse flush before the request
    int    stall;  // cycles with rsp_ready held low
  } test_t;

  logic  clk;
  logic  rst;
  logic  flush;
  logic  req_valid;
  logic  req_ready;
  addr_t req_addr;
  logic  rsp_valid;
  logic  rsp_ready;
  word_t rsp_data;
  resp_t rsp_resp;
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  logic  r_valid;
  logic  r_ready;
  word_t r_data;
  resp_t r_resp;
  int    ar_count;
  addr_t last_ar_addr;

  test_t tests[$];
  bit    table_ready;
  int    errors;
  int    test_errs;
  int    failed_tests;

  // reference state
  logic [TAG_W-1:0] m_tag [2][SETS];
  bit               m_valid [2][SETS];
  bit               m_lru [SETS];  // way to replace next

  icache_top #(.INDEX_W(INDEX_W)) u_dut (
    .clk, .rst, .flush_i(flush),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_addr_i(req_addr),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready),
    .rsp_data_o(rsp_data), .rsp_resp_o(rsp_resp),
    .mem_ar_valid_o(ar_valid), .mem_ar_ready_i(ar_ready), .mem_ar_addr_o(ar_addr),
    .mem_r_valid_i(r_valid), .mem_r_ready_o(r_ready),
    .mem_r_data_i(r_data), .mem_r_resp_i(r_resp)
  );

  tb_mem_model #(
    .PATTERN(PATTERN), .ERR_BASE(ERR_BASE), .ERR_LIMIT(ERR_LIMIT), .SEED(SEED)
  ) u_mem (
    .clk, .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_resp_o(r_resp),
    .ar_count_o(ar_count), .last_addr_o(last_ar_addr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic add_test(input string name, input addr_t addr, input bit fl, input int st);
    test_t t;
    t.name  = name;
    t.addr  = addr;
    t.flush = fl;
    t.stall = st;
    tests.push_back(t);
  endtask

  function automatic word_t expected_word(input addr_t a);
    addr_t w;
    w = {a[31:3], 3'b000};
    return {~w, w} ^ PATTERN;
  endfunction

  function automatic bit in_err_range(input addr_t a);
    return (a >= ERR_BASE) && (a < ERR_LIMIT);
  endfunction

  // predicts hit or miss and updates tags, valid bits and lru
  function automatic bit model_access(input addr_t a, input bit err);
    int               idx;
    logic [TAG_W-1:0] tag;
    bit               v;
    idx = a[OFFSET_W+INDEX_W-1:OFFSET_W];
    tag = a[31:OFFSET_W+INDEX_W];
    for (int w = 0; w < 2; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
        m_lru[idx] = (w == 0);
        return 1'b0;
      end
    end
    v = !m_valid[0][idx] ? 1'b0 : !m_valid[1][idx] ? 1'b1 : m_lru[idx];
    m_tag[v][idx]   = tag;
    m_valid[v][idx] = !err;  // error fill leaves the way empty
    if (!err) begin
      m_lru[idx] = !v;
    end
    return 1'b1;
  endfunction

  task automatic note_failure(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("** Error: %s: expected %h, actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      $display("** Error: %s: expected resp %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_miss(input string name, input bit exp, input bit act);
    if (exp !== act) begin
      $display("** Error: %s: expected miss %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("** Error: %s: expected burst address %h, actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  // handshake outputs low in reset, req_ready up in the first cycle after it
  task automatic check_reset();
    test_errs = 0;
    if (req_ready !== 1'b0 || rsp_valid !== 1'b0 ||
        ar_valid !== 1'b0 || r_ready !== 1'b0) begin
      note_failure("reset: handshake outputs not low during reset");
    end
    rst = 1'b0;
    next_cycle();
    if (req_ready !== 1'b1) begin
      note_failure("reset: req_ready not raised in the first cycle after reset");
    end
    $display("%-16s %s", "reset", (test_errs == 0) ? "ok" : "failed");
    errors += test_errs;
    failed_tests += (test_errs != 0);
  endtask

  task automatic run_test(input test_t t);
    bit    exp_miss;
    bit    err;
    int    count0;
    int    lat;
    word_t held_data;
    resp_t held_resp;
    test_errs = 0;
    err       = in_err_range(t.addr);
    if (t.flush) begin
      flush = 1'b1;
      next_cycle();
      flush = 1'b0;
      foreach (m_valid[w, s]) begin
        m_valid[w][s] = 1'b0;
      end
    end
    exp_miss  = model_access(t.addr, err);
    count0    = ar_count;
    rsp_ready = (t.stall == 0);
    req_valid = 1'b1;
    req_addr  = t.addr;
    while (!req_ready) begin
      next_cycle();
    end
    next_cycle();  // accepted on this edge
    req_valid = 1'b0;
    lat       = 1;
    while (!rsp_valid) begin
      next_cycle();
      lat++;
    end
    held_data = rsp_data;
    held_resp = rsp_resp;
    for (int i = 0; i < t.stall; i++) begin
      next_cycle();
      if (!rsp_valid || req_ready) begin
        note_failure($sformatf("%s: response dropped or new request taken in stall", t.name));
      end
      check_word({t.name, " stalled"}, held_data, rsp_data);
      check_resp({t.name, " stalled"}, held_resp, rsp_resp);
    end
    rsp_ready = 1'b1;
    next_cycle();
    check_miss(t.name, exp_miss, ar_count != count0);
    if (ar_count - count0 > 1) begin
      note_failure($sformatf("%s: %0d bursts for one miss", t.name, ar_count - count0));
    end
    if (exp_miss) begin
      check_addr(t.name, {t.addr[31:OFFSET_W], {OFFSET_W{1'b0}}}, last_ar_addr);
    end else if (lat != 1) begin
      note_failure($sformatf("%s: hit answered %0d cycles after acceptance", t.name, lat));
    end
    check_resp(t.name, err ? RESP_SLVERR : RESP_OKAY, held_resp);
    if (!err) begin
      check_word(t.name, expected_word(t.addr), held_data);
    end
    $display("%-16s %s", t.name, (test_errs == 0) ? "ok" : "failed");
    errors += test_errs;
    failed_tests += (test_errs != 0);
  endtask

  initial begin
    rst       = 1'b1;
    flush     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    rsp_ready = 1'b1;
    add_test("cold_set0_lo", 32'h0000_1000, 1'b0, 0);
    add_test("cold_set1_hi", 32'h0000_2018, 1'b0, 0);
    add_test("hit_set0_hi",  32'h0000_1008, 1'b0, 0);
    add_test("hit_set0_lo",  32'h0000_1004, 1'b0, 0);
    add_test("hit_set1_lo",  32'h0000_2010, 1'b0, 0);
    add_test("lru_fill_a",   32'h0000_4200, 1'b0, 0);
    add_test("lru_fill_b",   32'h0000_8208, 1'b0, 0);
    add_test("lru_touch_a",  32'h0000_4200, 1'b0, 0);
    add_test("lru_evict_b",  32'h0000_c200, 1'b0, 0);
    add_test("lru_keep_a",   32'h0000_4208, 1'b0, 0);
    add_test("lru_b_again",  32'h0000_8200, 1'b0, 0);
    add_test("lru_c_again",  32'h0000_c208, 1'b0, 0);
    add_test("stall_hit",    32'h0000_8200, 1'b0, 5);
    add_test("stall_miss",   32'h0001_0008, 1'b0, 3);
    add_test("err_line",     32'h0008_0040, 1'b0, 0);
    add_test("err_repeat",   32'h0008_0048, 1'b0, 2);
    add_test("flush_set0",   32'h0000_1000, 1'b1, 0);
    add_test("flush_set1",   32'h0000_2018, 1'b0, 0);
    add_test("refill_hit",   32'h0000_1008, 1'b0, 0);
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    check_reset();
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    $display("%0d tests, %0d failed, %0d errors", tests.size() + 1, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog, 64 cycles per test plus reset
  initial begin
    int limit;
    wait (table_ready);
    limit = (tests.size() + 1) * 64;
    repeat (limit) @(posedge clk);
    $display("run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
//////////////////////////////
// memory slave for the cache testbench
// answers two-beat bursts with data built from the word address
//////////////////////////////
`default_nettype none

module tb_mem_model #(
  parameter icache_pkg::word_t PATTERN   = '0,
  parameter icache_pkg::addr_t ERR_BASE  = '0,
  parameter icache_pkg::addr_t ERR_LIMIT = '0,
  parameter int unsigned       SEED      = 0
) (
  input  logic              clk,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  icache_pkg::addr_t ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output icache_pkg::word_t r_data_o,
  output icache_pkg::resp_t r_resp_o,
  output int                ar_count_o,
  output icache_pkg::addr_t last_addr_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import icache_pkg::*;

  // outputs change 1 ns after the edge, inputs are read there too
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  initial begin
    addr_t line;
    addr_t word_addr;
    bit    err;
    void'($urandom(SEED));  // stall pattern of the whole run
    ar_ready_o  = 1'b0;
    r_valid_o   = 1'b0;
    r_data_o    = '0;
    r_resp_o    = RESP_OKAY;
    ar_count_o  = 0;
    last_addr_o = '0;
    forever begin
      next_cycle();
      if (ar_valid_i === 1'b1) begin
        repeat ($urandom_range(3)) next_cycle();  // address stall
        ar_ready_o  = 1'b1;
        line        = ar_addr_i;
        last_addr_o = ar_addr_i;
        err         = (line >= ERR_BASE) && (line < ERR_LIMIT);
        next_cycle();
        ar_ready_o = 1'b0;
        ar_count_o = ar_count_o + 1;
        for (int b = 0; b < 2; b++) begin
          repeat ($urandom_range(3)) next_cycle();  // beat stall
          word_addr = {line[31:OFFSET_W], {OFFSET_W{1'b0}}} + (b * 8);
          r_valid_o = 1'b1;
          r_data_o  = {~word_addr, word_addr} ^ PATTERN;
          r_resp_o  = err ? RESP_SLVERR : RESP_OKAY;
          while (r_ready_i !== 1'b1) begin
            next_cycle();
          end
          next_cycle();
          r_valid_o = 1'b0;
          r_resp_o  = RESP_OKAY;
        end
      end
    end
  end

endmodule

`default_nettype wire
